/* hw/conv_pkg.sv */
`default_nettype none

package conv_pkg;

    // word format shared by data, weights and results
    localparam int CONV_WORD_W = 16;
    // fractional bits of the Q4.12 format
    localparam int CONV_FRAC_W = 12;
    // accumulator width with headroom for all products plus the bias
    localparam int CONV_ACC_W = 40;

    // frame geometry
    localparam int CONV_H = 8;
    localparam int CONV_KH = 3;
    // kernel width equals the number of input columns
    localparam int CONV_KW = 2;
    localparam int CONV_N_OUT = CONV_H - CONV_KH + 1;
    localparam int CONV_N_WORDS = CONV_H * CONV_KW;

    // kernel store addressing, weight slots first and the bias last
    localparam int CONV_BIAS_ADDR = CONV_KH * CONV_KW;
    localparam int CONV_WADDR_W = $clog2(CONV_KH * CONV_KW + 1);

    // index widths, kept at one bit at least
    localparam int CONV_ROW_W = (CONV_H > 1) ? $clog2(CONV_H) : 1;
    localparam int CONV_COL_W = (CONV_KW > 1) ? $clog2(CONV_KW) : 1;
    localparam int CONV_OUT_W = (CONV_N_OUT > 1) ? $clog2(CONV_N_OUT) : 1;

    // half an lsb of the result, added before the shift for round half up
    localparam logic signed [CONV_ACC_W-1:0] CONV_RND = 1 <<< (CONV_FRAC_W - 1);
    // result clamp limits at accumulator width
    localparam logic signed [CONV_ACC_W-1:0] CONV_SAT_MAX = (1 <<< (CONV_WORD_W - 1)) - 1;
    localparam logic signed [CONV_ACC_W-1:0] CONV_SAT_MIN = -(1 <<< (CONV_WORD_W - 1));

endpackage

`default_nettype wire

/* hw/conv_kernel_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_kernel_mem (
    input  logic                                clk_i,
    input  logic                                reset_i,
    input  logic                                wen_i,
    input  logic [conv_pkg::CONV_WADDR_W-1:0]   waddr_i,
    input  logic [conv_pkg::CONV_WORD_W-1:0]    wdata_i,
    input  logic [conv_pkg::CONV_COL_W-1:0]     col_i,
    output logic [conv_pkg::CONV_KH*conv_pkg::CONV_WORD_W-1:0] weights_o,
    output logic [conv_pkg::CONV_WORD_W-1:0]    bias_o
);
    import conv_pkg::*;

    // weight slot c*KH + r holds column c, kernel row r
    logic [CONV_WORD_W-1:0] weight_r [CONV_KH*CONV_KW];
    logic [CONV_WORD_W-1:0] bias_r;

    // single write port, one word per cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < CONV_KH * CONV_KW; i++) begin
                weight_r[i] <= '0;
            end
            bias_r <= '0;
        end else if (wen_i) begin
            if (waddr_i == CONV_WADDR_W'(CONV_BIAS_ADDR)) begin
                bias_r <= wdata_i;
            end else if (waddr_i < CONV_WADDR_W'(CONV_BIAS_ADDR)) begin
                weight_r[waddr_i] <= wdata_i;
            end
            // addresses past the bias slot are dropped
        end
    end

    // whole column out at once, so one accepted word reaches all its taps
    always_comb begin
        for (int k = 0; k < CONV_KH; k++) begin
            weights_o[k*CONV_WORD_W +: CONV_WORD_W] = weight_r[int'(col_i) * CONV_KH + k];
        end
    end

    assign bias_o = bias_r;

endmodule

`default_nettype wire

/* hw/conv_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic                              start_i,
    input  logic                              valid_i,
    output logic                              yumi_o,
    output logic                              busy_o,
    output logic                              sample_o,
    output logic                              clear_o,
    output logic                              drain_start_o,
    output logic [conv_pkg::CONV_ROW_W-1:0]   row_o,
    output logic [conv_pkg::CONV_COL_W-1:0]   col_o,
    input  logic                              drain_done_i
);
    import conv_pkg::*;

    // idle waits for start, clear zeroes the accumulators,
    // load takes the frame, drain waits for the result side
    enum logic [1:0] {
        S_IDLE  = 2'b00,
        S_CLEAR = 2'b01,
        S_LOAD  = 2'b11,
        S_DRAIN = 2'b10
    } state_r, state_n;

    // position of the word currently offered on the input
    logic [CONV_ROW_W-1:0] row_r;
    logic [CONV_COL_W-1:0] col_r;

    logic load_en;
    logic accept;
    logic row_last;
    logic col_last;
    logic frame_last;

    // the clear cycle may already accept, the first word lands on zeroed sums
    assign load_en = (state_r == S_CLEAR) || (state_r == S_LOAD);

    // demanding handshake, consume whatever is valid while loading
    assign yumi_o = load_en && valid_i;
    assign accept = yumi_o;

    assign row_last = (row_r == CONV_ROW_W'(CONV_H - 1));
    assign col_last = (col_r == CONV_COL_W'(CONV_KW - 1));
    // bottom word of the last column closes the frame
    assign frame_last = accept && row_last && col_last;

    // next state
    always_comb begin
        state_n = state_r;
        case (state_r)
            S_IDLE: begin
                // start only counts here
                if (start_i) begin
                    state_n = S_CLEAR;
                end
            end
            S_CLEAR: begin
                if (frame_last) begin
                    state_n = S_DRAIN;
                end else begin
                    state_n = S_LOAD;
                end
            end
            S_LOAD: begin
                if (frame_last) begin
                    state_n = S_DRAIN;
                end
            end
            S_DRAIN: begin
                // result side has sent its last word
                if (drain_done_i) begin
                    state_n = S_IDLE;
                end
            end
            default: begin
                state_n = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r <= S_IDLE;
        end else begin
            state_r <= state_n;
        end
    end

    // row steps first, column steps when a column is complete
    always_ff @(posedge clk_i) begin
        if (reset_i || (state_r == S_IDLE)) begin
            row_r <= '0;
            col_r <= '0;
        end else if (accept) begin
            if (row_last) begin
                row_r <= '0;
                if (col_last) begin
                    col_r <= '0;
                end else begin
                    col_r <= col_r + 1'b1;
                end
            end else begin
                row_r <= row_r + 1'b1;
            end
        end
    end

    assign sample_o = accept;
    assign row_o = row_r;
    assign col_o = col_r;
    // one cycle, right after start
    assign clear_o = (state_r == S_CLEAR);
    assign drain_start_o = frame_last;
    // high from the cycle after start until the drain is done
    assign busy_o = (state_r != S_IDLE);

endmodule

`default_nettype wire

/* hw/conv_mac_array.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_mac_array (
    input  logic                                     clk_i,
    input  logic                                     reset_i,
    input  logic                                     clear_i,
    input  logic                                     sample_i,
    input  logic [conv_pkg::CONV_ROW_W-1:0]          row_i,
    input  logic [conv_pkg::CONV_COL_W-1:0]          col_i,
    input  logic signed [conv_pkg::CONV_WORD_W-1:0]  data_i,
    input  logic [conv_pkg::CONV_KH*conv_pkg::CONV_WORD_W-1:0] weights_i,
    output logic [conv_pkg::CONV_N_OUT*conv_pkg::CONV_ACC_W-1:0] acc_o
);
    import conv_pkg::*;

    // one accumulator per output row
    // input row r feeds output o through kernel row r - o
    for (genvar o = 0; o < CONV_N_OUT; o++) begin : g_acc
        logic signed [CONV_ACC_W-1:0]    acc_r;
        logic signed [CONV_WORD_W-1:0]   wsel;
        logic signed [2*CONV_WORD_W-1:0] prod;
        logic signed [CONV_ACC_W-1:0]    prod_ext;
        logic signed [CONV_ACC_W-1:0]    base;
        logic                            hit;
        logic                            first;

        // pick the tap this row lands on, if any
        always_comb begin
            wsel = '0;
            hit = 1'b0;
            for (int k = 0; k < CONV_KH; k++) begin
                if (int'(row_i) == o + k) begin
                    wsel = weights_i[k*CONV_WORD_W +: CONV_WORD_W];
                    hit = 1'b1;
                end
            end
        end

        // full Q8.24 product
        assign prod = data_i * wsel;
        // sign extends, both sides signed
        assign prod_ext = prod;

        // first term of a result is column 0, kernel row 0
        assign first = (col_i == '0) && (int'(row_i) == o);

        // first term loads and later terms add
        always_comb begin
            if (clear_i || first) begin
                base = '0;
            end else begin
                base = acc_r;
            end
        end

        always_ff @(posedge clk_i) begin
            if (reset_i) begin
                acc_r <= '0;
            end else if (sample_i && hit) begin
                acc_r <= base + prod_ext;
            end else if (clear_i) begin
                acc_r <= '0;
            end
        end

        assign acc_o[o*CONV_ACC_W +: CONV_ACC_W] = acc_r;
    end

endmodule

`default_nettype wire

/* hw/conv_result.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_result (
    input  logic                                             clk_i,
    input  logic                                             reset_i,
    input  logic                                             drain_start_i,
    input  logic                                             ready_i,
    input  logic [conv_pkg::CONV_N_OUT*conv_pkg::CONV_ACC_W-1:0] acc_i,
    input  logic [conv_pkg::CONV_WORD_W-1:0]                 bias_i,
    output logic                                             valid_o,
    output logic                                             drain_done_o,
    output logic [conv_pkg::CONV_WORD_W-1:0]                 data_o
);
    import conv_pkg::*;

    logic                          active_r;
    logic [CONV_OUT_W-1:0]         idx_r;
    logic                          xfer;
    logic                          idx_last;
    logic signed [CONV_ACC_W-1:0]  acc_sel;
    logic signed [CONV_ACC_W-1:0]  bias_ext;
    logic signed [CONV_ACC_W-1:0]  sum;
    logic signed [CONV_ACC_W-1:0]  shifted;

    assign xfer = active_r && ready_i;
    assign idx_last = (idx_r == CONV_OUT_W'(CONV_N_OUT - 1));

    // drain flag and result index
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            active_r <= 1'b0;
            idx_r <= '0;
        end else if (drain_start_i) begin
            active_r <= 1'b1;
            idx_r <= '0;
        end else if (xfer) begin
            if (idx_last) begin
                active_r <= 1'b0;
                idx_r <= '0;
            end else begin
                idx_r <= idx_r + 1'b1;
            end
        end
    end

    // selected accumulator, Q8.24 at accumulator width
    assign acc_sel = acc_i[int'(idx_r)*CONV_ACC_W +: CONV_ACC_W];
    // bias moved up to 24 fractional bits
    assign bias_ext = $signed(bias_i);
    assign sum = acc_sel + (bias_ext <<< CONV_FRAC_W) + CONV_RND;
    // back to 12 fractional bits, floor after the half lsb gives round half up
    assign shifted = sum >>> CONV_FRAC_W;

    // clamp into Q4.12
    always_comb begin
        if (shifted > CONV_SAT_MAX) begin
            data_o = CONV_SAT_MAX[CONV_WORD_W-1:0];
        end else if (shifted < CONV_SAT_MIN) begin
            data_o = CONV_SAT_MIN[CONV_WORD_W-1:0];
        end else begin
            data_o = shifted[CONV_WORD_W-1:0];
        end
    end

    assign valid_o = active_r;
    // tells the sequencer the frame is finished
    assign drain_done_o = xfer && idx_last;

endmodule

`default_nettype wire

/* hw/conv_layer.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_layer (
    input  logic                                    clk_i,
    input  logic                                    reset_i,
    input  logic                                    start_i,
    input  logic                                    valid_i,
    input  logic signed [conv_pkg::CONV_WORD_W-1:0] data_i,
    input  logic                                    ready_i,
    input  logic                                    wen_i,
    input  logic [conv_pkg::CONV_WADDR_W-1:0]       waddr_i,
    input  logic [conv_pkg::CONV_WORD_W-1:0]        wdata_i,
    output logic                                    yumi_o,
    output logic                                    valid_o,
    output logic [conv_pkg::CONV_WORD_W-1:0]        data_o,
    output logic                                    busy_o
);
    import conv_pkg::*;

    // sequencer to datapath
    logic                              sample;
    logic                              clear;
    logic                              drain_start;
    logic                              drain_done;
    logic [CONV_ROW_W-1:0]             row;
    logic [CONV_COL_W-1:0]             col;
    // kernel column and bias
    logic [CONV_KH*CONV_WORD_W-1:0]    weights;
    logic [CONV_WORD_W-1:0]            bias;
    // finished sums
    logic [CONV_N_OUT*CONV_ACC_W-1:0]  acc;

    conv_ctrl ctrl0 (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .start_i       (start_i),
        .valid_i       (valid_i),
        .yumi_o        (yumi_o),
        .busy_o        (busy_o),
        .sample_o      (sample),
        .clear_o       (clear),
        .drain_start_o (drain_start),
        .row_o         (row),
        .col_o         (col),
        .drain_done_i  (drain_done)
    );

    conv_kernel_mem kmem0 (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .wen_i     (wen_i),
        .waddr_i   (waddr_i),
        .wdata_i   (wdata_i),
        .col_i     (col),
        .weights_o (weights),
        .bias_o    (bias)
    );

    conv_mac_array mac0 (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .clear_i   (clear),
        .sample_i  (sample),
        .row_i     (row),
        .col_i     (col),
        .data_i    (data_i),
        .weights_i (weights),
        .acc_o     (acc)
    );

    conv_result res0 (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .drain_start_i (drain_start),
        .ready_i       (ready_i),
        .acc_i         (acc),
        .bias_i        (bias),
        .valid_o       (valid_o),
        .drain_done_o  (drain_done),
        .data_o        (data_o)
    );

endmodule

`default_nettype wire

/* include/conv_tb_ref.svh */
`ifndef CONV_TB_REF_SVH
`define CONV_TB_REF_SVH

// round half up and clamp a Q8.24 sum back to Q4.12
function automatic logic [conv_pkg::CONV_WORD_W-1:0] round_saturate(
    input longint sum_q24
);
    longint shifted;
    longint lim_hi;
    longint lim_lo;

    lim_hi = (longint'(1) <<< (conv_pkg::CONV_WORD_W - 1)) - 1;
    lim_lo = -(longint'(1) <<< (conv_pkg::CONV_WORD_W - 1));
    // add half an lsb and floor
    shifted = (sum_q24 + (longint'(1) <<< (conv_pkg::CONV_FRAC_W - 1)))
              >>> conv_pkg::CONV_FRAC_W;
    if (shifted > lim_hi) begin
        shifted = lim_hi;
    end else if (shifted < lim_lo) begin
        shifted = lim_lo;
    end
    return shifted[conv_pkg::CONV_WORD_W-1:0];
endfunction

// expected results of one frame
// frame is indexed [column][row] and kern [column][kernel row]
function automatic void expected_results(
    input  logic signed [conv_pkg::CONV_WORD_W-1:0] frame [conv_pkg::CONV_KW][conv_pkg::CONV_H],
    input  logic signed [conv_pkg::CONV_WORD_W-1:0] kern [conv_pkg::CONV_KW][conv_pkg::CONV_KH],
    input  logic signed [conv_pkg::CONV_WORD_W-1:0] bias,
    output logic [conv_pkg::CONV_WORD_W-1:0]        res [conv_pkg::CONV_N_OUT]
);
    longint acc;

    for (int o = 0; o < conv_pkg::CONV_N_OUT; o++) begin
        // bias starts the sum at 24 fractional bits
        acc = longint'(bias) <<< conv_pkg::CONV_FRAC_W;
        for (int c = 0; c < conv_pkg::CONV_KW; c++) begin
            for (int k = 0; k < conv_pkg::CONV_KH; k++) begin
                acc = acc + longint'(kern[c][k]) * longint'(frame[c][o + k]);
            end
        end
        res[o] = round_saturate(acc);
    end
endfunction

`endif

/* sim/conv_layer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_layer_tb;
    import conv_pkg::*;

    `include "conv_tb_ref.svh"

    // identity, 20 plain, 10 stalled, 3 corner, 2 rewrite
    localparam int N_FRAMES = 36;
    localparam int TIMEOUT_CYCLES = N_FRAMES * (CONV_N_WORDS + CONV_N_OUT + 4) * 4;

    logic clk_i, reset_i, start_i, valid_i, ready_i, wen_i;
    logic signed [CONV_WORD_W-1:0] data_i;
    logic [CONV_WADDR_W-1:0] waddr_i;
    logic [CONV_WORD_W-1:0] wdata_i;
    logic yumi_o, valid_o, busy_o;
    logic [CONV_WORD_W-1:0] data_o;

    // frame in flight indexed [column][row] and kernel indexed [column][kernel row]
    logic signed [CONV_WORD_W-1:0] frame [CONV_KW][CONV_H];
    logic signed [CONV_WORD_W-1:0] kern [CONV_KW][CONV_KH];
    logic signed [CONV_WORD_W-1:0] bias_v;
    logic [CONV_WORD_W-1:0] exp_res [CONV_N_OUT];
    logic [CONV_WORD_W-1:0] exp_q [$];

    // ready pattern for back-pressure drawn once after seeding
    logic bp_pat [256];
    logic bp_en = 1'b0;
    int mismatch_cnt = 0;
    int other_cnt = 0;
    int cycle_cnt = 0;
    int xfer_cnt = 0;
    logic stall_prev = 1'b0;
    logic idle_due = 1'b0;
    logic [CONV_WORD_W-1:0] data_prev = '0;

    conv_layer dut0 (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .start_i (start_i),
        .valid_i (valid_i),
        .data_i  (data_i),
        .ready_i (ready_i),
        .wen_i   (wen_i),
        .waddr_i (waddr_i),
        .wdata_i (wdata_i),
        .yumi_o  (yumi_o),
        .valid_o (valid_o),
        .data_o  (data_o),
        .busy_o  (busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // sink ready moves 2 ns after the edge like the other inputs
    initial begin : drive_ready
        int n;
        n = 0;
        ready_i = 1'b1;
        forever begin
            @(posedge clk_i);
            #2;
            ready_i = bp_en ? bp_pat[n % 256] : 1'b1;
            n++;
        end
    end

    // run limit sized from the frame count with room for stalls
    initial begin
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("run stopped by timeout after %0d cycles", cycle_cnt);
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        $display("STATUS: FAIL");
        $finish;
    end

    // output checker samples mid cycle where inputs and outputs have settled
    always @(negedge clk_i) begin : check_out
        logic [CONV_WORD_W-1:0] want;
        if (!reset_i) begin
            // busy drops at the edge of the last transfer
            if (idle_due && busy_o !== 1'b0) begin
                $display("Mismatch busy_o after last transfer: expected %h got %h", 1'b0, busy_o);
                mismatch_cnt++;
            end
            idle_due = 1'b0;
            if (stall_prev && valid_o === 1'b1 && data_o !== data_prev) begin
                $display("Mismatch data_o while stalled: expected %h got %h", data_prev, data_o);
                mismatch_cnt++;
            end
            if (valid_o === 1'b1 && ready_i === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("output %h transferred with no result expected", data_o);
                    other_cnt++;
                end else begin
                    want = exp_q.pop_front();
                    if (data_o !== want) begin
                        $display("Mismatch data_o: expected %h got %h", want, data_o);
                        mismatch_cnt++;
                    end
                end
                if (busy_o !== 1'b1) begin
                    $display("Mismatch busy_o during drain: expected %h got %h", 1'b1, busy_o);
                    mismatch_cnt++;
                end
                xfer_cnt++;
                idle_due = (xfer_cnt % CONV_N_OUT) == 0;
            end
            stall_prev = (valid_o === 1'b1) && (ready_i !== 1'b1);
            data_prev = data_o;
        end
    end

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic wait_idle();
        while (busy_o !== 1'b0) begin
            next_cycle();
        end
    endtask

    function automatic logic signed [CONV_WORD_W-1:0] rand_word(input int span);
        int v;
        v = int'($urandom % 32'(2 * span)) - span;
        return v[CONV_WORD_W-1:0];
    endfunction

    task automatic fill_kernel(input int span_w, input int span_b);
        for (int c = 0; c < CONV_KW; c++) begin
            for (int k = 0; k < CONV_KH; k++) begin
                kern[c][k] = (span_w == 0) ? '0 : rand_word(span_w);
            end
        end
        bias_v = (span_b == 0) ? '0 : rand_word(span_b);
    endtask

    task automatic fill_frame(input int span);
        for (int c = 0; c < CONV_KW; c++) begin
            for (int r = 0; r < CONV_H; r++) begin
                frame[c][r] = rand_word(span);
            end
        end
    endtask

    // weights go to slot c*KH + k and the bias to the slot after them
    task automatic write_kernel();
        wait_idle();
        wen_i = 1'b1;
        for (int c = 0; c < CONV_KW; c++) begin
            for (int k = 0; k < CONV_KH; k++) begin
                waddr_i = CONV_WADDR_W'(c * CONV_KH + k);
                wdata_i = kern[c][k];
                next_cycle();
            end
        end
        waddr_i = CONV_WADDR_W'(CONV_KH * CONV_KW);
        wdata_i = bias_v;
        next_cycle();
        wen_i = 1'b0;
    endtask

    // hold the word until yumi and let the following edge consume it
    task automatic send_word(input logic signed [CONV_WORD_W-1:0] w, input bit gaps);
        int idle;
        idle = gaps ? int'($urandom % 3) : 0;
        repeat (idle) next_cycle();
        valid_i = 1'b1;
        data_i = w;
        #1;
        while (yumi_o !== 1'b1) begin
            @(posedge clk_i);
            #3;
        end
        next_cycle();
        valid_i = 1'b0;
    endtask

    // stray raises start once mid load and once in the drain
    task automatic run_frame(input bit gaps, input bit stray);
        expected_results(frame, kern, bias_v, exp_res);
        for (int o = 0; o < CONV_N_OUT; o++) begin
            exp_q.push_back(exp_res[o]);
        end
        wait_idle();
        start_i = 1'b1;
        next_cycle();
        start_i = 1'b0;
        for (int c = 0; c < CONV_KW; c++) begin
            for (int r = 0; r < CONV_H; r++) begin
                start_i = stray && (c == 0) && (r == CONV_H / 2);
                send_word(frame[c][r], gaps);
                start_i = 1'b0;
            end
        end
        if (stray) begin
            start_i = 1'b1;
            next_cycle();
            start_i = 1'b0;
        end
    endtask

    // reference values worked out by hand from the rounding rule
    task automatic check_ref(input int idx, input logic [CONV_WORD_W-1:0] want);
        if (exp_res[idx] !== want) begin
            $display("Mismatch reference result %0d: expected %h got %h", idx, want, exp_res[idx]);
            mismatch_cnt++;
        end
    endtask

    initial begin
        void'($urandom(32'h5514_09f1));
        reset_i = 1'b1;
        start_i = 1'b0;
        valid_i = 1'b0;
        data_i = '0;
        wen_i = 1'b0;
        waddr_i = '0;
        wdata_i = '0;
        for (int i = 0; i < 256; i++) begin
            bp_pat[i] = ($urandom % 3) != 0;
        end
        repeat (4) @(posedge clk_i);
        #2;
        reset_i = 1'b0;

        // an offered word must not be taken while idle after reset
        valid_i = 1'b1;
        repeat (4) begin
            #1;
            if (yumi_o !== 1'b0 || valid_o !== 1'b0 || busy_o !== 1'b0) begin
                $display("Mismatch yumi_o/valid_o/busy_o while idle: expected 0 got %h%h%h",
                         yumi_o, valid_o, busy_o);
                mismatch_cnt++;
            end
            next_cycle();
        end
        valid_i = 1'b0;

        // single 1.0 tap passes column 0 straight through
        fill_kernel(0, 0);
        kern[0][0] = 16'h1000;
        write_kernel();
        fill_frame(16'h8000);
        run_frame(1'b0, 1'b0);
        for (int o = 0; o < CONV_N_OUT; o++) begin
            check_ref(o, frame[0][o]);
        end

        // random frames without stalls
        repeat (20) begin
            fill_kernel(16'h1000, 16'h2000);
            write_kernel();
            fill_frame(16'h2000);
            run_frame(1'b0, 1'b0);
        end

        // input gaps and output back-pressure
        bp_en = 1'b1;
        repeat (10) begin
            fill_kernel(16'h1000, 16'h4000);
            write_kernel();
            fill_frame(16'h8000);
            run_frame(1'b1, 1'b0);
        end
        wait_idle();
        bp_en = 1'b0;

        // positive saturation
        for (int c = 0; c < CONV_KW; c++) begin
            for (int k = 0; k < CONV_KH; k++) begin
                kern[c][k] = 16'h7fff;
            end
            for (int r = 0; r < CONV_H; r++) begin
                frame[c][r] = 16'h7fff;
            end
        end
        bias_v = 16'h7fff;
        write_kernel();
        run_frame(1'b0, 1'b0);
        check_ref(0, 16'h7fff);
        // negative saturation
        for (int c = 0; c < CONV_KW; c++) begin
            for (int r = 0; r < CONV_H; r++) begin
                frame[c][r] = 16'h8000;
            end
        end
        bias_v = 16'h8000;
        write_kernel();
        run_frame(1'b0, 1'b0);
        check_ref(0, 16'h8000);
        // 0.5 tap on odd inputs lands every result on a half lsb
        fill_kernel(0, 0);
        kern[0][0] = 16'h0800;
        write_kernel();
        fill_frame(16'h8000);
        for (int r = 0; r < CONV_H; r++) begin
            frame[0][r] = (r % 2 == 0) ? 16'(2 * r + 1) : -16'(2 * r - 1);
        end
        run_frame(1'b0, 1'b0);
        check_ref(0, 16'h0001);
        check_ref(1, 16'h0000);
        check_ref(2, 16'h0003);
        check_ref(3, 16'hfffe);

        // same frame under two kernels with stray starts while busy
        fill_kernel(16'h1000, 16'h2000);
        write_kernel();
        fill_frame(16'h4000);
        run_frame(1'b0, 1'b1);
        fill_kernel(16'h1000, 16'h2000);
        write_kernel();
        run_frame(1'b0, 1'b1);

        wait_idle();
        repeat (4) next_cycle();
        if (exp_q.size() != 0) begin
            $display("%0d expected results never came out", exp_q.size());
            other_cnt++;
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
hw/conv_pkg.sv
hw/conv_kernel_mem.sv
hw/conv_ctrl.sv
hw/conv_mac_array.sv
hw/conv_result.sv
hw/conv_layer.sv
sim/conv_layer_tb.sv
